/* instrDecoder.f */
mipsIsaPkg.sv
decodeCtrlPkg.sv
instrFieldsIf.sv
specialDecoder.sv
opcodeDecoder.sv
instrDecoder.sv
tb_instrDecoder.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_instrDecoder
FILELIST  ?= instrDecoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'all tests passed' $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_instrDecoder.sv */
`timescale 1ns/10ps

module tb_instrDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int RANDOM_N    = 300;
    localparam int STALL_N     = 200;
    localparam int RESET_CYC   = 10;
    localparam int SPECIAL_CYC = 15 + 2;
    localparam int OPCODE_CYC  = 17 + 2;
    localparam int RANDOM_CYC  = RANDOM_N + 2;
    localparam int STALL_CYC   = STALL_N + 2;
    localparam int TOTAL_CYC   = RESET_CYC + SPECIAL_CYC + OPCODE_CYC + RANDOM_CYC + STALL_CYC;
    localparam int TIMEOUT_NS  = (TOTAL_CYC + 20) * CLK_PERIOD;

    localparam logic [5:0] FN_LIST [15] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_JR,
        FN_SYSCALL, FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_NOR, FN_SLT, FN_SLTU, 6'd1};
    localparam logic [5:0] OP_LIST [14] = '{OP_LUI, OP_LB, OP_LW, OP_SW, OP_ADDI, OP_ADDIU,
        OP_ANDI, OP_ORI, OP_SLTI, OP_BEQ, OP_BNE, OP_BLEZ, OP_J, OP_JAL};
    localparam logic [4:0] CP0_LIST [3] = '{CP0_MF, CP0_MT, CP0_ERET};

    typedef struct packed {
        logic       valid;
        ctrlWordT   c;                                    // destSel unused here
        logic [4:0] dest;
    } expT;

    logic        clk;
    logic        rstN;
    logic        stall;
    logic        instrValid;
    logic [31:0] instr;
    logic        ctrlValid, regWrite, regDst, aluSrc, memWrite, memToReg, loadByte;
    logic        loadUpper, branchEq, branchNe, branchLez, jump, jumpLink, jumpReg;
    logic        syscall, eret, mfc0, mtc0, dependA, dependB, illegal;
    logic [3:0]  aluOp;
    logic [1:0]  extOp;
    logic [4:0]  destReg;

    expT    expQ[$];
    expT    cur = '0;
    integer seed;
    int     errCount = 0;
    int     checkCount = 0;
    int     testCount = 0;
    int     failCount = 0;
    int     testErrStart = 0;

    instrDecoder dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // expected decode from the instruction table
    ////////////////////////////////////////////////////////////////////////////

    function automatic expT refDecode(input logic [31:0] w);
        expT        e;
        logic [5:0] op;
        logic [5:0] fn;
        e       = '0;
        op      = w[31:26];
        fn      = w[5:0];
        e.valid = 1'b1;
        if (op == OP_SPECIAL) begin
            case (fn)
                FN_SLL, FN_SRL, FN_SRA: begin
                    e.c.aluOp = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                    e.c.extOp    = EXT_SHAMT;
                    e.c.aluSrc   = 1'b1;
                    e.c.regWrite = 1'b1;
                    e.c.regDst   = 1'b1;
                    e.c.dependA  = 1'b1;
                    e.dest       = w[15:11];
                end
                FN_SLLV, FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_NOR, FN_SLT, FN_SLTU: begin
                    case (fn)
                        FN_SLLV: e.c.aluOp = ALU_NONE;
                        FN_SUB:  e.c.aluOp = ALU_SUB;
                        FN_AND:  e.c.aluOp = ALU_AND;
                        FN_OR:   e.c.aluOp = ALU_OR;
                        FN_NOR:  e.c.aluOp = ALU_NOR;
                        FN_SLT:  e.c.aluOp = ALU_SLT;
                        FN_SLTU: e.c.aluOp = ALU_SLTU;
                        default: e.c.aluOp = ALU_ADD;     // add, addu
                    endcase
                    e.c.regWrite = 1'b1;
                    e.c.regDst   = 1'b1;
                    e.c.dependA  = 1'b1;
                    e.c.dependB  = 1'b1;
                    e.dest       = w[15:11];
                end
                FN_JR: begin
                    e.c.aluOp   = ALU_NONE;
                    e.c.jumpReg = 1'b1;
                    e.c.dependA = 1'b1;
                end
                FN_SYSCALL: begin
                    e.c.aluOp   = ALU_NONE;
                    e.c.syscall = 1'b1;
                    e.c.dependA = 1'b1;
                    e.c.dependB = 1'b1;
                end
                default: e.c.illegal = 1'b1;
            endcase
        end else begin
            case (op)
                OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_SLTI, OP_LW, OP_LB, OP_LUI: begin
                    e.c.aluOp = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR :
                        (op == OP_SLTI || op == OP_LUI) ? ALU_SLT : ALU_ADD;
                    e.c.extOp     = (op == OP_ORI) ? EXT_ZERO : EXT_SIGN;
                    e.c.regWrite  = 1'b1;
                    e.c.aluSrc    = (op != OP_LUI);
                    e.c.dependA   = (op != OP_LUI);       // lui reads no register
                    e.c.memToReg  = (op == OP_LW || op == OP_LB);
                    e.c.loadByte  = (op == OP_LB);
                    e.c.loadUpper = (op == OP_LUI);
                    e.dest        = w[20:16];
                end
                OP_SW: begin
                    e.c.aluOp    = ALU_ADD;
                    e.c.aluSrc   = 1'b1;
                    e.c.memWrite = 1'b1;
                    e.c.dependA  = 1'b1;
                    e.c.dependB  = 1'b1;
                end
                OP_BEQ, OP_BNE: begin
                    e.c.aluOp    = ALU_NONE;
                    e.c.branchEq = (op == OP_BEQ);
                    e.c.branchNe = (op == OP_BNE);
                    e.c.dependA  = 1'b1;
                    e.c.dependB  = 1'b1;
                end
                OP_BLEZ: begin
                    e.c.aluOp     = ALU_SLT;
                    e.c.branchLez = 1'b1;
                    e.c.dependA   = 1'b1;
                end
                OP_J: begin
                    e.c.aluOp = ALU_NONE;
                    e.c.jump  = 1'b1;
                end
                OP_JAL: begin
                    e.c.aluOp    = ALU_NONE;
                    e.c.jumpLink = 1'b1;
                    e.c.regWrite = 1'b1;
                    e.dest       = LINK_REG;
                end
                OP_COP0: begin
                    case (w[25:21])
                        CP0_MF: begin
                            e.c.regWrite = 1'b1;
                            e.c.mfc0     = 1'b1;
                        end
                        CP0_MT:   e.c.mtc0 = 1'b1;
                        CP0_ERET: e.c.eret = 1'b1;
                        default:  e.c.illegal = 1'b1;
                    endcase
                end
                default: e.c.illegal = 1'b1;
            endcase
        end
        return e;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] expV, input logic [31:0] actV);
        checkCount++;
        if (actV !== expV) begin
            errCount++;
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expV, actV);
        end
    endtask

    task automatic driveCycle(input logic [31:0] w, input logic v, input logic s);
        @(negedge clk);
        instr      = w;
        instrValid = v;
        stall      = s;
    endtask

    task automatic finishTest(input string name);
        int errs;
        driveCycle('0, 1'b0, 1'b0);                       // drain the last one
        driveCycle('0, 1'b0, 1'b0);
        errs = errCount - testErrStart;
        testErrStart = errCount;
        testCount++;
        if (errs != 0) failCount++;
        $display("test %s %s, %0d mismatches", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // expectation queue and compare
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rstN && !stall) begin
            if (instrValid) expQ.push_back(refDecode(instr));
            else expQ.push_back('0);                      // bubble
        end
    end

    always @(negedge clk) begin
        if (!rstN) begin
            expQ.delete();                                // stage cleared by reset
            cur = '0;
        end else if (expQ.size() > 0) begin
            cur = expQ.pop_front();                       // empty while stalled
        end
        checkVal("ctrlValid", 32'(cur.valid), 32'(ctrlValid));
        checkVal("aluOp", 32'(cur.c.aluOp), 32'(aluOp));
        checkVal("extOp", 32'(cur.c.extOp), 32'(extOp));
        checkVal("regWrite", 32'(cur.c.regWrite), 32'(regWrite));
        checkVal("regDst", 32'(cur.c.regDst), 32'(regDst));
        checkVal("aluSrc", 32'(cur.c.aluSrc), 32'(aluSrc));
        checkVal("memWrite", 32'(cur.c.memWrite), 32'(memWrite));
        checkVal("memToReg", 32'(cur.c.memToReg), 32'(memToReg));
        checkVal("loadByte", 32'(cur.c.loadByte), 32'(loadByte));
        checkVal("loadUpper", 32'(cur.c.loadUpper), 32'(loadUpper));
        checkVal("branchEq", 32'(cur.c.branchEq), 32'(branchEq));
        checkVal("branchNe", 32'(cur.c.branchNe), 32'(branchNe));
        checkVal("branchLez", 32'(cur.c.branchLez), 32'(branchLez));
        checkVal("jump", 32'(cur.c.jump), 32'(jump));
        checkVal("jumpLink", 32'(cur.c.jumpLink), 32'(jumpLink));
        checkVal("jumpReg", 32'(cur.c.jumpReg), 32'(jumpReg));
        checkVal("syscall", 32'(cur.c.syscall), 32'(syscall));
        checkVal("eret", 32'(cur.c.eret), 32'(eret));
        checkVal("mfc0", 32'(cur.c.mfc0), 32'(mfc0));
        checkVal("mtc0", 32'(cur.c.mtc0), 32'(mtc0));
        checkVal("destReg", 32'(cur.dest), 32'(destReg));
        checkVal("dependA", 32'(cur.c.dependA), 32'(dependA));
        checkVal("dependB", 32'(cur.c.dependB), 32'(dependB));
        checkVal("illegal", 32'(cur.c.illegal), 32'(illegal));
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: simulation did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] w;
        logic        v;
        logic        s;
        logic        lastStall;
        clk        = 1'b0;
        rstN       = 1'b0;
        stall      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        seed       = 32'h120e_64a4;
        w          = '0;
        v          = 1'b0;
        lastStall  = 1'b0;

        repeat (2) @(negedge clk);
        rstN = 1'b1;
        w    = {OP_JAL, 26'h3ff_ffff};
        driveCycle(w, 1'b1, 1'b0);
        driveCycle(w, 1'b1, 1'b1);                        // live word held by stall
        @(negedge clk);
        rstN <= 1'b0;                                     // lands after this edge's checks
        repeat (2) @(negedge clk);
        rstN <= 1'b1;
        finishTest("reset");

        for (int i = 0; i < 15; i++) begin
            r = $random(seed);
            driveCycle({OP_SPECIAL, r[25:6], FN_LIST[i]}, 1'b1, 1'b0);
        end
        finishTest("special");

        for (int i = 0; i < 14; i++) begin
            r = $random(seed);
            driveCycle({OP_LIST[i], r[25:0]}, 1'b1, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            driveCycle({OP_COP0, CP0_LIST[i], r[20:0]}, 1'b1, 1'b0);
        end
        finishTest("opcode");

        for (int i = 0; i < RANDOM_N; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            driveCycle(r, r2[0], 1'b0);
        end
        finishTest("random");

        for (int i = 0; i < STALL_N; i++) begin
            r2 = $random(seed);
            s  = (r2[1:0] == 2'b00);
            if (!lastStall) begin                         // upstream holds while stalled
                r = $random(seed);
                if (r[31]) w = {OP_SPECIAL, r[25:6], FN_LIST[int'(r[30:27]) % 15]};
                else w = {OP_LIST[int'(r[30:27]) % 14], r[25:0]};
                v = (r2[4:2] != 3'b000);
            end
            driveCycle(w, v, s);
            lastStall = s;
        end
        finishTest("stall");

        $display("tests: %0d run, %0d failing; checks: %0d, errors: %0d",
                 testCount, failCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               instrValid,
    input  logic [INSTR_W-1:0] instr,
    output logic               ctrlValid,
    output logic [3:0]         aluOp,
    output logic [1:0]         extOp,
    output logic               regWrite,
    output logic               regDst,
    output logic               aluSrc,
    output logic               memWrite,
    output logic               memToReg,
    output logic               loadByte,
    output logic               loadUpper,
    output logic               branchEq,
    output logic               branchNe,
    output logic               branchLez,
    output logic               jump,
    output logic               jumpLink,
    output logic               jumpReg,
    output logic               syscall,
    output logic               eret,
    output logic               mfc0,
    output logic               mtc0,
    output logic [REG_W-1:0]   destReg,
    output logic               dependA,
    output logic               dependB,
    output logic               illegal
);

    instrFieldsIf fieldsBus ();

    ctrlWordT         specialCtrl;
    ctrlWordT         opcodeCtrl;
    ctrlWordT         selCtrl;
    ctrlWordT         ctrlQ;
    logic [REG_W-1:0] destNext;
    logic [REG_W-1:0] destQ;

    assign fieldsBus.op   = instr[31:26];
    assign fieldsBus.rs   = instr[25:21];
    assign fieldsBus.rt   = instr[20:16];
    assign fieldsBus.rd   = instr[15:11];
    assign fieldsBus.func = instr[5:0];

    specialDecoder specialDec_i (
        .fields (fieldsBus),
        .ctrl   (specialCtrl)
    );

    opcodeDecoder opcodeDec_i (
        .fields (fieldsBus),
        .ctrl   (opcodeCtrl)
    );

    assign selCtrl = (fieldsBus.op == OP_SPECIAL) ? specialCtrl : opcodeCtrl;

    always_comb begin
        case (selCtrl.destSel)
            DEST_RT:   destNext = fieldsBus.rt;
            DEST_RD:   destNext = fieldsBus.rd;
            DEST_LINK: destNext = LINK_REG;
            default:   destNext = '0;                     // nothing written back
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode register, holds while stalled
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrlQ     <= '0;
            destQ     <= '0;
        end else if (!stall) begin
            ctrlValid <= instrValid;
            ctrlQ     <= instrValid ? selCtrl : '0;      // bubbles carry no flags
            destQ     <= instrValid ? destNext : '0;
        end
    end

    assign aluOp     = ctrlQ.aluOp;
    assign extOp     = ctrlQ.extOp;
    assign regWrite  = ctrlQ.regWrite;
    assign regDst    = ctrlQ.regDst;
    assign aluSrc    = ctrlQ.aluSrc;
    assign memWrite  = ctrlQ.memWrite;
    assign memToReg  = ctrlQ.memToReg;
    assign loadByte  = ctrlQ.loadByte;
    assign loadUpper = ctrlQ.loadUpper;
    assign branchEq  = ctrlQ.branchEq;
    assign branchNe  = ctrlQ.branchNe;
    assign branchLez = ctrlQ.branchLez;
    assign jump      = ctrlQ.jump;
    assign jumpLink  = ctrlQ.jumpLink;
    assign jumpReg   = ctrlQ.jumpReg;
    assign syscall   = ctrlQ.syscall;
    assign eret      = ctrlQ.eret;
    assign mfc0      = ctrlQ.mfc0;
    assign mtc0      = ctrlQ.mtc0;
    assign destReg   = destQ;
    assign dependA   = ctrlQ.dependA;
    assign dependB   = ctrlQ.dependB;
    assign illegal   = ctrlQ.illegal;

endmodule

/* opcodeDecoder.sv */
`timescale 1ns/10ps

module opcodeDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
    instrFieldsIf.dec fields,
    output ctrlWordT  ctrl
);

    // immediate form writing rt
    function automatic ctrlWordT immOp(input aluOpT op, input extOpT ext);
        ctrlWordT c;
        c          = '0;
        c.aluOp    = op;
        c.extOp    = ext;
        c.regWrite = 1'b1;
        c.aluSrc   = 1'b1;
        c.destSel  = DEST_RT;
        c.dependA  = 1'b1;
        return c;
    endfunction

    // branch or jump, no register write
    function automatic ctrlWordT flowOp(input logic readA, input logic readB);
        ctrlWordT c;
        c         = '0;
        c.aluOp   = ALU_NONE;
        c.dependA = readA;
        c.dependB = readB;
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // primary opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        case (fields.op)
            OP_ADDI:  ctrl = immOp(ALU_ADD, EXT_SIGN);
            OP_ADDIU: ctrl = immOp(ALU_ADD, EXT_SIGN);
            OP_ANDI:  ctrl = immOp(ALU_AND, EXT_SIGN);
            OP_ORI:   ctrl = immOp(ALU_OR, EXT_ZERO);
            OP_SLTI:  ctrl = immOp(ALU_SLT, EXT_SIGN);
            OP_LW: begin
                ctrl          = immOp(ALU_ADD, EXT_SIGN);
                ctrl.memToReg = 1'b1;
            end
            OP_LB: begin
                ctrl          = immOp(ALU_ADD, EXT_SIGN);
                ctrl.memToReg = 1'b1;
                ctrl.loadByte = 1'b1;
            end
            OP_SW: begin
                ctrl          = immOp(ALU_ADD, EXT_SIGN);
                ctrl.regWrite = 1'b0;
                ctrl.memWrite = 1'b1;
                ctrl.destSel  = DEST_NONE;
                ctrl.dependB  = 1'b1;                     // store data in rt
            end
            OP_LUI: begin
                ctrl           = immOp(ALU_SLT, EXT_SIGN);
                ctrl.aluSrc    = 1'b0;                    // imm goes via lui path
                ctrl.loadUpper = 1'b1;
                ctrl.dependA   = 1'b0;
            end
            OP_BEQ: begin
                ctrl          = flowOp(1'b1, 1'b1);
                ctrl.branchEq = 1'b1;
            end
            OP_BNE: begin
                ctrl          = flowOp(1'b1, 1'b1);
                ctrl.branchNe = 1'b1;
            end
            OP_BLEZ: begin
                ctrl           = flowOp(1'b1, 1'b0);
                ctrl.aluOp     = ALU_SLT;
                ctrl.branchLez = 1'b1;
            end
            OP_J: begin
                ctrl      = flowOp(1'b0, 1'b0);
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl          = flowOp(1'b0, 1'b0);
                ctrl.jumpLink = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = DEST_LINK;
            end
            OP_COP0: begin
                case (fields.rs)
                    CP0_MF: begin
                        ctrl.regWrite = 1'b1;             // no forwarding from cp0
                        ctrl.mfc0     = 1'b1;
                    end
                    CP0_MT:   ctrl.mtc0 = 1'b1;
                    CP0_ERET: ctrl.eret = 1'b1;
                    default:  ctrl.illegal = 1'b1;
                endcase
            end
            default: begin
                ctrl.illegal = 1'b1;                      // SPECIAL lands here too
            end
        endcase
    end

endmodule

/* specialDecoder.sv */
`timescale 1ns/10ps

module specialDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
    instrFieldsIf.dec fields,
    output ctrlWordT  ctrl
);

    // register-register op, or a shift by the shamt field
    function automatic ctrlWordT regOp(input aluOpT op, input logic shiftImm);
        ctrlWordT c;
        c          = '0;
        c.aluOp    = op;
        c.extOp    = shiftImm ? EXT_SHAMT : EXT_SIGN;
        c.regWrite = 1'b1;
        c.regDst   = 1'b1;
        c.aluSrc   = shiftImm;
        c.destSel  = DEST_RD;
        c.dependA  = 1'b1;
        c.dependB  = !shiftImm;                           // shamt replaces rt
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // function field decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        case (fields.func)
            FN_SLL:  ctrl = regOp(ALU_SLL, 1'b1);
            FN_SRL:  ctrl = regOp(ALU_SRL, 1'b1);
            FN_SRA:  ctrl = regOp(ALU_SRA, 1'b1);
            FN_SLLV: ctrl = regOp(ALU_NONE, 1'b0);         // shared code 13
            FN_ADD:  ctrl = regOp(ALU_ADD, 1'b0);
            FN_ADDU: ctrl = regOp(ALU_ADD, 1'b0);
            FN_SUB:  ctrl = regOp(ALU_SUB, 1'b0);
            FN_AND:  ctrl = regOp(ALU_AND, 1'b0);
            FN_OR:   ctrl = regOp(ALU_OR, 1'b0);
            FN_NOR:  ctrl = regOp(ALU_NOR, 1'b0);
            FN_SLT:  ctrl = regOp(ALU_SLT, 1'b0);
            FN_SLTU: ctrl = regOp(ALU_SLTU, 1'b0);
            FN_JR: begin
                ctrl.aluOp   = ALU_NONE;
                ctrl.jumpReg = 1'b1;
                ctrl.dependA = 1'b1;                      // target from rs
            end
            FN_SYSCALL: begin
                ctrl.aluOp   = ALU_NONE;
                ctrl.syscall = 1'b1;
                ctrl.dependA = 1'b1;                      // service regs read
                ctrl.dependB = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* instrFieldsIf.sv */
`timescale 1ns/10ps

interface instrFieldsIf import mipsIsaPkg::*; ();

    logic [OP_W-1:0]  op;
    logic [OP_W-1:0]  func;
    logic [REG_W-1:0] rs;                                 // also cop0 format
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] rd;

    // driven by the decode stage top
    modport src (
        output op,
        output func,
        output rs,
        output rt,
        output rd
    );

    // read by the special and opcode decoders
    modport dec (
        input op,
        input func,
        input rs,
        input rt,
        input rd
    );

endinterface

/* decodeCtrlPkg.sv */
package decodeCtrlPkg;

    // alu operation, codes shared with the execute stage
    typedef enum logic [3:0] {
        ALU_SLL  = 4'd0,
        ALU_SRA  = 4'd1,
        ALU_SRL  = 4'd2,
        ALU_ADD  = 4'd5,
        ALU_SUB  = 4'd6,
        ALU_AND  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_NOR  = 4'd10,
        ALU_SLT  = 4'd11,
        ALU_SLTU = 4'd12,
        ALU_NONE = 4'd13                                  // also sllv
    } aluOpT;

    typedef enum logic [1:0] {
        EXT_SIGN  = 2'd0,
        EXT_ZERO  = 2'd1,
        EXT_SHAMT = 2'd2                                  // instr[10:6]
    } extOpT;

    // source of the destination register index
    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_RT   = 2'd1,
        DEST_RD   = 2'd2,
        DEST_LINK = 2'd3
    } destSelT;

    typedef struct packed {
        aluOpT   aluOp;
        extOpT   extOp;
        logic    regWrite;
        logic    regDst;
        logic    aluSrc;                                  // b operand is imm
        logic    memWrite;
        logic    memToReg;
        logic    loadByte;
        logic    loadUpper;
        logic    branchEq;
        logic    branchNe;
        logic    branchLez;
        logic    jump;
        logic    jumpLink;
        logic    jumpReg;
        logic    syscall;
        logic    eret;
        logic    mfc0;
        logic    mtc0;
        destSelT destSel;
        logic    dependA;                                 // reads rs
        logic    dependB;                                 // reads rt
        logic    illegal;
    } ctrlWordT;

endpackage

/* mipsIsaPkg.sv */
package mipsIsaPkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int INSTR_W = 32;                          // instruction word
    localparam int OP_W    = 6;                           // opcode and funct
    localparam int REG_W   = 5;                           // register index

    ////////////////////////////////////////////////////////////////////////////
    // primary opcodes, instr[31:26]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [OP_W-1:0] OP_SPECIAL = 6'd0;        // decoded on funct
    localparam logic [OP_W-1:0] OP_J       = 6'd2;
    localparam logic [OP_W-1:0] OP_JAL     = 6'd3;
    localparam logic [OP_W-1:0] OP_BEQ     = 6'd4;
    localparam logic [OP_W-1:0] OP_BNE     = 6'd5;
    localparam logic [OP_W-1:0] OP_BLEZ    = 6'd6;
    localparam logic [OP_W-1:0] OP_ADDI    = 6'd8;
    localparam logic [OP_W-1:0] OP_ADDIU   = 6'd9;
    localparam logic [OP_W-1:0] OP_SLTI    = 6'd10;
    localparam logic [OP_W-1:0] OP_ANDI    = 6'd12;
    localparam logic [OP_W-1:0] OP_ORI     = 6'd13;
    localparam logic [OP_W-1:0] OP_LUI     = 6'd15;
    localparam logic [OP_W-1:0] OP_COP0    = 6'd16;       // format in rs
    localparam logic [OP_W-1:0] OP_LB      = 6'd32;
    localparam logic [OP_W-1:0] OP_LW      = 6'd35;
    localparam logic [OP_W-1:0] OP_SW      = 6'd43;

    ////////////////////////////////////////////////////////////////////////////
    // SPECIAL function codes, instr[5:0]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [OP_W-1:0] FN_SLL     = 6'd0;
    localparam logic [OP_W-1:0] FN_SRL     = 6'd2;
    localparam logic [OP_W-1:0] FN_SRA     = 6'd3;
    localparam logic [OP_W-1:0] FN_SLLV    = 6'd4;
    localparam logic [OP_W-1:0] FN_JR      = 6'd8;
    localparam logic [OP_W-1:0] FN_SYSCALL = 6'd12;
    localparam logic [OP_W-1:0] FN_ADD     = 6'd32;
    localparam logic [OP_W-1:0] FN_ADDU    = 6'd33;
    localparam logic [OP_W-1:0] FN_SUB     = 6'd34;
    localparam logic [OP_W-1:0] FN_AND     = 6'd36;
    localparam logic [OP_W-1:0] FN_OR      = 6'd37;
    localparam logic [OP_W-1:0] FN_NOR     = 6'd39;
    localparam logic [OP_W-1:0] FN_SLT     = 6'd42;
    localparam logic [OP_W-1:0] FN_SLTU    = 6'd43;

    // coprocessor 0 formats, carried in the rs field
    localparam logic [REG_W-1:0] CP0_MF   = 5'd0;
    localparam logic [REG_W-1:0] CP0_MT   = 5'd4;
    localparam logic [REG_W-1:0] CP0_ERET = 5'd16;

    localparam logic [REG_W-1:0] LINK_REG = 5'd31;        // $ra for jal

endpackage
